//--- exe_defs.svh
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// datapath word width
`define EXE_XLEN 32

// register file address width
`define EXE_REG_AW 5

// mcause code reported with an ebreak
// machine-mode environment call, sized to one data word
`define EXE_CAUSE_EBREAK (`EXE_XLEN'(11))

`endif

//--- exe_ctrl_pkg.sv
`default_nettype none

package exe_ctrl_pkg;

	// integer operation codes, unused codes give zero
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_SLL   = 4'd2,
		ALU_SLT   = 4'd3,
		ALU_SLTU  = 4'd4,
		ALU_XOR   = 4'd5,
		ALU_SRL   = 4'd6,
		ALU_SRA   = 4'd7,
		ALU_OR    = 4'd8,
		ALU_AND   = 4'd9,
		ALU_COPY2 = 4'd10
	} alu_op_e;

	// first operand source
	typedef enum logic [1:0] {
		SRC1_ZERO = 2'd0,
		SRC1_RS1  = 2'd1,
		SRC1_PC   = 2'd2,
		SRC1_CSR  = 2'd3
	} src1_sel_e;

	// second operand source, four is the link offset for jal/jalr
	typedef enum logic [1:0] {
		SRC2_ZERO = 2'd0,
		SRC2_RS2  = 2'd1,
		SRC2_IMM  = 2'd2,
		SRC2_FOUR = 2'd3
	} src2_sel_e;

	typedef enum logic [2:0] {
		CSR_NONE  = 3'd0,
		CSR_CSRRW = 3'd1,
		CSR_CSRRS = 3'd2
	} csr_op_e;

	typedef enum logic [2:0] {
		LOAD_NONE = 3'd0,
		LOAD_LB   = 3'd1,
		LOAD_LH   = 3'd2,
		LOAD_LW   = 3'd3,
		LOAD_LBU  = 3'd4,
		LOAD_LHU  = 3'd5
	} load_kind_e;

	typedef enum logic [1:0] {
		STORE_NONE = 2'd0,
		STORE_SB   = 2'd1,
		STORE_SH   = 2'd2,
		STORE_SW   = 2'd3
	} store_kind_e;

endpackage

`default_nettype wire

//--- exe_bus_pkg.sv
`default_nettype none

`include "exe_defs.svh"

package exe_bus_pkg;

	// decoded instruction as handed over by decode
	typedef struct packed {
		logic [`EXE_XLEN-1:0]      rs1;
		logic [`EXE_XLEN-1:0]      rs2;
		logic [`EXE_XLEN-1:0]      pc;
		logic [`EXE_XLEN-1:0]      imm;
		logic [`EXE_XLEN-1:0]      csr_rdata;
		exe_ctrl_pkg::alu_op_e     alu_op;
		exe_ctrl_pkg::src1_sel_e   src1_sel;
		exe_ctrl_pkg::src2_sel_e   src2_sel;
		exe_ctrl_pkg::csr_op_e     csr_op;
		exe_ctrl_pkg::load_kind_e  load_kind;
		exe_ctrl_pkg::store_kind_e store_kind;
		logic                      wd;
		logic [`EXE_REG_AW-1:0]    wreg;
		logic                      ebreak;
	} id_ex_payload_t;

	// execute result for the load/store stage
	typedef struct packed {
		logic [`EXE_XLEN-1:0]      alu_result;
		logic [`EXE_XLEN-1:0]      mem_wdata;
		logic [`EXE_XLEN-1:0]      csr_wdata;
		logic [`EXE_XLEN-1:0]      csr_mcause;
		logic [`EXE_XLEN-1:0]      pc;
		logic                      mem_wen;
		exe_ctrl_pkg::load_kind_e  load_kind;
		exe_ctrl_pkg::store_kind_e store_kind;
		exe_ctrl_pkg::csr_op_e     csr_op;
		logic                      wd;
		logic [`EXE_REG_AW-1:0]    wreg;
		logic                      ebreak;
	} ex_ls_payload_t;

endpackage

`default_nettype wire

//--- exe_if.sv
`timescale 1ns/10ps
`default_nettype none

// decode to execute handoff
interface id_ex_if;

	logic                        valid;
	logic                        ready;
	exe_bus_pkg::id_ex_payload_t payload;

	// payload held stable by decode while valid is high
	modport decode (
		output valid,
		output payload,
		input  ready
	);

	modport exe (
		input  valid,
		input  payload,
		output ready
	);

endinterface

// execute to load/store handoff
interface ex_ls_if;

	logic                        valid;
	logic                        ready;
	exe_bus_pkg::ex_ls_payload_t payload;

	modport exe (
		output valid,
		output payload,
		input  ready
	);

	modport lsu (
		input  valid,
		input  payload,
		output ready
	);

endinterface

`default_nettype wire

//--- exe_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_defs.svh"

module exe_alu (
	input  wire logic [`EXE_XLEN-1:0] src1_i,
	input  wire logic [`EXE_XLEN-1:0] src2_i,
	input  exe_ctrl_pkg::alu_op_e     op_i,
	output logic [`EXE_XLEN-1:0]      result_o
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// rv32 shifts only look at the low five bits
	assign shamt = src2_i[4:0];

	assign lt_signed   = $signed(src1_i) < $signed(src2_i);
	assign lt_unsigned = src1_i < src2_i;

	always_comb begin
		case (op_i)
			exe_ctrl_pkg::ALU_ADD:   result_o = src1_i + src2_i;
			exe_ctrl_pkg::ALU_SUB:   result_o = src1_i - src2_i;
			exe_ctrl_pkg::ALU_SLL:   result_o = src1_i << shamt;
			exe_ctrl_pkg::ALU_SLT:   result_o = {{(`EXE_XLEN-1){1'b0}}, lt_signed};
			exe_ctrl_pkg::ALU_SLTU:  result_o = {{(`EXE_XLEN-1){1'b0}}, lt_unsigned};
			exe_ctrl_pkg::ALU_XOR:   result_o = src1_i ^ src2_i;
			exe_ctrl_pkg::ALU_SRL:   result_o = src1_i >> shamt;
			exe_ctrl_pkg::ALU_SRA:   result_o = $unsigned($signed(src1_i) >>> shamt);
			exe_ctrl_pkg::ALU_OR:    result_o = src1_i | src2_i;
			exe_ctrl_pkg::ALU_AND:   result_o = src1_i & src2_i;
			// lui passes the upper immediate straight through
			exe_ctrl_pkg::ALU_COPY2: result_o = src2_i;
			default:                 result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- exe_operand_sel.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_defs.svh"

module exe_operand_sel (
	input  wire logic [`EXE_XLEN-1:0] rs1_i,
	input  wire logic [`EXE_XLEN-1:0] rs2_i,
	input  wire logic [`EXE_XLEN-1:0] pc_i,
	input  wire logic [`EXE_XLEN-1:0] imm_i,
	input  wire logic [`EXE_XLEN-1:0] csr_rdata_i,
	input  exe_ctrl_pkg::src1_sel_e   src1_sel_i,
	input  exe_ctrl_pkg::src2_sel_e   src2_sel_i,
	input  exe_ctrl_pkg::csr_op_e     csr_op_i,
	output logic [`EXE_XLEN-1:0]      src1_o,
	output logic [`EXE_XLEN-1:0]      src2_o,
	output logic [`EXE_XLEN-1:0]      csr_wdata_o
);

	// first operand
	always_comb begin
		case (src1_sel_i)
			exe_ctrl_pkg::SRC1_RS1: src1_o = rs1_i;
			exe_ctrl_pkg::SRC1_PC:  src1_o = pc_i;
			exe_ctrl_pkg::SRC1_CSR: src1_o = csr_rdata_i;
			default:                src1_o = '0;
		endcase
	end

	// second operand
	always_comb begin
		case (src2_sel_i)
			exe_ctrl_pkg::SRC2_RS2:  src2_o = rs2_i;
			exe_ctrl_pkg::SRC2_IMM:  src2_o = imm_i;
			exe_ctrl_pkg::SRC2_FOUR: src2_o = `EXE_XLEN'(4);
			default:                 src2_o = '0;
		endcase
	end

	// csrrs sets the bits of rs1 on top of the current value
	always_comb begin
		case (csr_op_i)
			exe_ctrl_pkg::CSR_CSRRW: csr_wdata_o = rs1_i;
			exe_ctrl_pkg::CSR_CSRRS: csr_wdata_o = rs1_i | csr_rdata_i;
			default:                 csr_wdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- exe_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_defs.svh"

module exe_stage (
	input wire logic clock,
	input wire logic reset,
	id_ex_if.exe     id_i,
	ex_ls_if.exe     ls_o
);

	localparam logic [1:0] ST_WAIT_ID = 2'b00;
	localparam logic [1:0] ST_RUN     = 2'b01;
	localparam logic [1:0] ST_WAIT_LS = 2'b10;

	logic [1:0]                  state;
	logic [1:0]                  state_next;
	logic [`EXE_XLEN-1:0]        src1;
	logic [`EXE_XLEN-1:0]        src2;
	logic [`EXE_XLEN-1:0]        alu_result;
	logic [`EXE_XLEN-1:0]        csr_wdata;
	exe_bus_pkg::ex_ls_payload_t result;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_WAIT_ID;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_WAIT_ID: begin
				if (id_i.valid) begin
					state_next = ST_RUN;
				end
			end
			// back-pressure wins over an idle decode
			ST_RUN: begin
				if (!ls_o.ready) begin
					state_next = ST_WAIT_LS;
				end else if (!id_i.valid) begin
					state_next = ST_WAIT_ID;
				end
			end
			ST_WAIT_LS: begin
				if (ls_o.ready) begin
					state_next = ST_WAIT_ID;
				end
			end
			default: begin
				state_next = ST_WAIT_ID;
			end
		endcase
	end

	assign id_i.ready = (state == ST_WAIT_ID) || (state == ST_RUN);
	assign ls_o.valid = (state == ST_RUN) || (state == ST_WAIT_LS);

	exe_operand_sel i_operand_sel (
		.rs1_i       (id_i.payload.rs1),
		.rs2_i       (id_i.payload.rs2),
		.pc_i        (id_i.payload.pc),
		.imm_i       (id_i.payload.imm),
		.csr_rdata_i (id_i.payload.csr_rdata),
		.src1_sel_i  (id_i.payload.src1_sel),
		.src2_sel_i  (id_i.payload.src2_sel),
		.csr_op_i    (id_i.payload.csr_op),
		.src1_o      (src1),
		.src2_o      (src2),
		.csr_wdata_o (csr_wdata)
	);

	exe_alu i_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.op_i     (id_i.payload.alu_op),
		.result_o (alu_result)
	);

	// result fields, mostly passed through for load/store and writeback
	always_comb begin
		result.alu_result = alu_result;
		result.mem_wdata  = id_i.payload.rs2;
		result.csr_wdata  = csr_wdata;
		result.csr_mcause = `EXE_CAUSE_EBREAK;
		result.pc         = id_i.payload.pc;
		result.mem_wen    = (id_i.payload.store_kind != exe_ctrl_pkg::STORE_NONE);
		result.load_kind  = id_i.payload.load_kind;
		result.store_kind = id_i.payload.store_kind;
		result.csr_op     = id_i.payload.csr_op;
		result.wd         = id_i.payload.wd;
		result.wreg       = id_i.payload.wreg;
		result.ebreak     = id_i.payload.ebreak;
	end

	assign ls_o.payload = result;

	// nothing offered downstream right after reset
	a_valid_low_after_reset: assert property (
		@(posedge clock) reset |=> !ls_o.valid
	);

	// payload is combinational, so this holds only if decode keeps
	// its instruction until load/store has taken the result
	a_payload_stable_stalled: assert property (
		@(posedge clock) disable iff (reset)
		(ls_o.valid && !ls_o.ready) |=> $stable(ls_o.payload)
	);

	a_state_legal: assert property (
		@(posedge clock) disable iff (reset) state != 2'b11
	);

endmodule

`default_nettype wire

//--- exe_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_defs.svh"

module exe_top (
	input  wire logic                   clock,
	input  wire logic                   reset,

	// decode side
	input  wire logic                   id_valid_i,
	output logic                        exu_ready_o,
	input  wire logic [`EXE_XLEN-1:0]   rs1_i,
	input  wire logic [`EXE_XLEN-1:0]   rs2_i,
	input  wire logic [`EXE_XLEN-1:0]   pc_i,
	input  wire logic [`EXE_XLEN-1:0]   imm_i,
	input  wire logic [`EXE_XLEN-1:0]   csr_rdata_i,
	input  exe_ctrl_pkg::alu_op_e       alu_op_i,
	input  exe_ctrl_pkg::src1_sel_e     src1_sel_i,
	input  exe_ctrl_pkg::src2_sel_e     src2_sel_i,
	input  exe_ctrl_pkg::csr_op_e       csr_op_i,
	input  exe_ctrl_pkg::load_kind_e    load_kind_i,
	input  exe_ctrl_pkg::store_kind_e   store_kind_i,
	input  wire logic                   wd_i,
	input  wire logic [`EXE_REG_AW-1:0] wreg_i,
	input  wire logic                   ebreak_i,

	// load/store side
	input  wire logic                   lsu_ready_i,
	output logic                        exu_valid_o,
	output logic [`EXE_XLEN-1:0]        alu_result_o,
	output logic [`EXE_XLEN-1:0]        mem_wdata_o,
	output logic [`EXE_XLEN-1:0]        csr_wdata_o,
	output logic [`EXE_XLEN-1:0]        csr_mcause_o,
	output logic [`EXE_XLEN-1:0]        pc_o,
	output logic                        mem_wen_o,
	output exe_ctrl_pkg::load_kind_e    load_kind_o,
	output exe_ctrl_pkg::store_kind_e   store_kind_o,
	output exe_ctrl_pkg::csr_op_e       csr_op_o,
	output logic                        wd_o,
	output logic [`EXE_REG_AW-1:0]      wreg_o,
	output logic                        ebreak_o
);

	id_ex_if id_bus ();
	ex_ls_if ls_bus ();

	assign id_bus.valid   = id_valid_i;
	assign exu_ready_o    = id_bus.ready;
	assign id_bus.payload = '{
		rs1:        rs1_i,
		rs2:        rs2_i,
		pc:         pc_i,
		imm:        imm_i,
		csr_rdata:  csr_rdata_i,
		alu_op:     alu_op_i,
		src1_sel:   src1_sel_i,
		src2_sel:   src2_sel_i,
		csr_op:     csr_op_i,
		load_kind:  load_kind_i,
		store_kind: store_kind_i,
		wd:         wd_i,
		wreg:       wreg_i,
		ebreak:     ebreak_i
	};

	assign ls_bus.ready = lsu_ready_i;
	assign exu_valid_o  = ls_bus.valid;

	assign alu_result_o = ls_bus.payload.alu_result;
	assign mem_wdata_o  = ls_bus.payload.mem_wdata;
	assign csr_wdata_o  = ls_bus.payload.csr_wdata;
	assign csr_mcause_o = ls_bus.payload.csr_mcause;
	assign pc_o         = ls_bus.payload.pc;
	assign mem_wen_o    = ls_bus.payload.mem_wen;
	assign load_kind_o  = ls_bus.payload.load_kind;
	assign store_kind_o = ls_bus.payload.store_kind;
	assign csr_op_o     = ls_bus.payload.csr_op;
	assign wd_o         = ls_bus.payload.wd;
	assign wreg_o       = ls_bus.payload.wreg;
	assign ebreak_o     = ls_bus.payload.ebreak;

	exe_stage i_stage (
		.clock (clock),
		.reset (reset),
		.id_i  (id_bus.exe),
		.ls_o  (ls_bus.exe)
	);

endmodule

`default_nettype wire

//--- tb_exe_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exe_checker (
	input wire logic                   clock,
	input wire logic                   reset,
	input wire logic                   id_valid_i,
	input wire logic                   exu_ready_i,
	input wire logic                   exu_valid_i,
	input wire logic                   lsu_ready_i,
	input exe_bus_pkg::ex_ls_payload_t expected_i,
	input exe_bus_pkg::ex_ls_payload_t actual_i
);

	// expected results of accepted instructions in order of acceptance
	exe_bus_pkg::ex_ls_payload_t pending[$];
	exe_bus_pkg::ex_ls_payload_t held;
	exe_bus_pkg::ex_ls_payload_t want;
	logic                        stalled = 1'b0;
	logic                        accepted = 1'b0;
	string                       test_name = "none";
	int                          pass_count = 0;
	int                          fail_count = 0;
	int                          checked_count = 0;

	always @(posedge clock) begin
		if (reset) begin
			stalled = 1'b0;
			accepted = 1'b0;
		end else begin
			// result is offered one cycle after acceptance
			if (accepted && !exu_valid_i) begin
				$display("%s: no result offered in the cycle after an accepted instruction",
					test_name);
				fail_count++;
			end
			// a stalled result must hold until load/store takes it
			if (stalled && (!exu_valid_i || exu_ready_i)) begin
				$display("%s: valid fell or decode ready rose during a stall", test_name);
				fail_count++;
			end
			if (stalled && actual_i !== held) begin
				$display("[FAIL] %s (stall): expected %h, actual %h", test_name, held, actual_i);
				fail_count++;
			end
			if (id_valid_i && exu_ready_i) begin
				pending.push_back(expected_i);
			end
			if (exu_valid_i && lsu_ready_i) begin
				if (pending.size() == 0) begin
					$display("%s: a result was sent with no instruction accepted", test_name);
					fail_count++;
				end else begin
					want = pending.pop_front();
					if (actual_i === want) begin
						pass_count++;
					end else begin
						$display("[FAIL] %s: expected %h, actual %h", test_name, want, actual_i);
						fail_count++;
					end
				end
				checked_count++;
			end
			accepted = id_valid_i && exu_ready_i;
			stalled = exu_valid_i && !lsu_ready_i;
			held = actual_i;
		end
	end

endmodule

`default_nettype wire

//--- tb_exe.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_defs.svh"

module tb_exe;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 10;
	localparam int N_ALU        = 64;
	localparam int N_SRC        = 32;
	localparam int N_CSR        = 18;
	localparam int N_MEM        = 24;
	localparam int N_HS         = 24;
	localparam int NUM_INSTR    = N_ALU + N_SRC + N_CSR + N_MEM + N_HS;

	logic                          clock;
	logic                          reset;
	logic                          id_valid;
	logic                          lsu_ready;
	logic                          exu_ready_o;
	logic                          exu_valid_o;
	exe_bus_pkg::id_ex_payload_t   stim;
	exe_bus_pkg::ex_ls_payload_t   expected;
	wire exe_bus_pkg::ex_ls_payload_t actual;
	integer                        seed;
	int                            sent;
	int                            tb_fails;

	exe_top i_dut (
		.clock        (clock),
		.reset        (reset),
		.id_valid_i   (id_valid),
		.exu_ready_o  (exu_ready_o),
		.rs1_i        (stim.rs1),
		.rs2_i        (stim.rs2),
		.pc_i         (stim.pc),
		.imm_i        (stim.imm),
		.csr_rdata_i  (stim.csr_rdata),
		.alu_op_i     (stim.alu_op),
		.src1_sel_i   (stim.src1_sel),
		.src2_sel_i   (stim.src2_sel),
		.csr_op_i     (stim.csr_op),
		.load_kind_i  (stim.load_kind),
		.store_kind_i (stim.store_kind),
		.wd_i         (stim.wd),
		.wreg_i       (stim.wreg),
		.ebreak_i     (stim.ebreak),
		.lsu_ready_i  (lsu_ready),
		.exu_valid_o  (exu_valid_o),
		.alu_result_o (actual.alu_result),
		.mem_wdata_o  (actual.mem_wdata),
		.csr_wdata_o  (actual.csr_wdata),
		.csr_mcause_o (actual.csr_mcause),
		.pc_o         (actual.pc),
		.mem_wen_o    (actual.mem_wen),
		.load_kind_o  (actual.load_kind),
		.store_kind_o (actual.store_kind),
		.csr_op_o     (actual.csr_op),
		.wd_o         (actual.wd),
		.wreg_o       (actual.wreg),
		.ebreak_o     (actual.ebreak)
	);

	tb_exe_checker i_checker (
		.clock       (clock),
		.reset       (reset),
		.id_valid_i  (id_valid),
		.exu_ready_i (exu_ready_o),
		.exu_valid_i (exu_valid_o),
		.lsu_ready_i (lsu_ready),
		.expected_i  (expected),
		.actual_i    (actual)
	);

	// expected execute result for one decoded instruction
	function automatic exe_bus_pkg::ex_ls_payload_t exe_model(
		input exe_bus_pkg::id_ex_payload_t in
	);
		exe_bus_pkg::ex_ls_payload_t out;
		logic [`EXE_XLEN-1:0]        a;
		logic [`EXE_XLEN-1:0]        b;
		logic [4:0]                  sh;
		case (in.src1_sel)
			exe_ctrl_pkg::SRC1_ZERO: a = '0;
			exe_ctrl_pkg::SRC1_RS1:  a = in.rs1;
			exe_ctrl_pkg::SRC1_PC:   a = in.pc;
			default:                 a = in.csr_rdata;
		endcase
		case (in.src2_sel)
			exe_ctrl_pkg::SRC2_ZERO: b = '0;
			exe_ctrl_pkg::SRC2_RS2:  b = in.rs2;
			exe_ctrl_pkg::SRC2_IMM:  b = in.imm;
			default:                 b = 32'd4;
		endcase
		sh = b[4:0];
		case (in.alu_op)
			exe_ctrl_pkg::ALU_ADD:   out.alu_result = a + b;
			exe_ctrl_pkg::ALU_SUB:   out.alu_result = a + ~b + 32'd1;
			exe_ctrl_pkg::ALU_SLL:   out.alu_result = a << sh;
			// differing signs decide a signed compare on their own
			exe_ctrl_pkg::ALU_SLT:   out.alu_result = (a[31] != b[31]) ? {31'd0, a[31]}
			                                                           : {31'd0, a < b};
			exe_ctrl_pkg::ALU_SLTU:  out.alu_result = {31'd0, a < b};
			exe_ctrl_pkg::ALU_XOR:   out.alu_result = a ^ b;
			exe_ctrl_pkg::ALU_SRL:   out.alu_result = a >> sh;
			exe_ctrl_pkg::ALU_SRA:   out.alu_result = (a >> sh)
			                                        | (a[31] ? ~(32'hffff_ffff >> sh) : '0);
			exe_ctrl_pkg::ALU_OR:    out.alu_result = a | b;
			exe_ctrl_pkg::ALU_AND:   out.alu_result = a & b;
			exe_ctrl_pkg::ALU_COPY2: out.alu_result = b;
			default:                 out.alu_result = '0;
		endcase
		case (in.csr_op)
			exe_ctrl_pkg::CSR_CSRRW: out.csr_wdata = in.rs1;
			exe_ctrl_pkg::CSR_CSRRS: out.csr_wdata = in.rs1 | in.csr_rdata;
			default:                 out.csr_wdata = '0;
		endcase
		out.mem_wdata  = in.rs2;
		out.csr_mcause = `EXE_XLEN'(11);
		out.pc         = in.pc;
		out.mem_wen    = (in.store_kind == exe_ctrl_pkg::STORE_SB)
		                 || (in.store_kind == exe_ctrl_pkg::STORE_SH)
		                 || (in.store_kind == exe_ctrl_pkg::STORE_SW);
		out.load_kind  = in.load_kind;
		out.store_kind = in.store_kind;
		out.csr_op     = in.csr_op;
		out.wd         = in.wd;
		out.wreg       = in.wreg;
		out.ebreak     = in.ebreak;
		return out;
	endfunction

	always_comb begin
		expected = exe_model(stim);
	end

	// random instruction shaped for the test at hand
	function automatic exe_bus_pkg::id_ex_payload_t make_instr(input int kind, input int idx);
		exe_bus_pkg::id_ex_payload_t p;
		logic [31:0]                 r;
		p.rs1        = $random(seed);
		p.rs2        = $random(seed);
		p.pc         = $random(seed);
		p.imm        = $random(seed);
		p.csr_rdata  = $random(seed);
		r            = $random(seed);
		p.alu_op     = exe_ctrl_pkg::alu_op_e'(r[3:0]);
		p.src1_sel   = exe_ctrl_pkg::src1_sel_e'(r[5:4]);
		p.src2_sel   = exe_ctrl_pkg::src2_sel_e'(r[7:6]);
		p.csr_op     = exe_ctrl_pkg::csr_op_e'(r[10:8] % 3'd3);
		p.load_kind  = exe_ctrl_pkg::load_kind_e'(r[14:12] % 3'd6);
		p.store_kind = exe_ctrl_pkg::store_kind_e'(r[17:16]);
		p.wd         = r[18];
		p.wreg       = r[23:19];
		p.ebreak     = r[24];
		case (kind)
			0: begin
				p.src1_sel = exe_ctrl_pkg::SRC1_RS1;
				p.src2_sel = exe_ctrl_pkg::SRC2_RS2;
				p.alu_op   = exe_ctrl_pkg::alu_op_e'(idx[3:0]);
				if (idx[4]) begin
					p.rs2[4:0] = 5'd31;
				end
				// negative against positive splits signed from unsigned
				if (idx[5]) begin
					p.rs1[31] = 1'b1;
					p.rs2[31] = 1'b0;
				end
			end
			1: begin
				p.src1_sel = exe_ctrl_pkg::src1_sel_e'(idx[1:0]);
				p.src2_sel = exe_ctrl_pkg::src2_sel_e'(idx[3:2]);
			end
			2: begin
				p.csr_op = exe_ctrl_pkg::csr_op_e'(idx[2:0] % 3'd3);
			end
			default: begin
			end
		endcase
		return p;
	endfunction

	function automatic logic random_ready(input int pct);
		logic [31:0] r;
		r = $random(seed);
		return (r % 100) < pct;
	endfunction

	// runs from one rising edge up to the edge of the last transfer
	task automatic run_test(input string name, input int kind, input int count, input int pct);
		int fails_before;
		int i;
		fails_before = i_checker.fail_count;
		i_checker.test_name = name;
		for (i = 0; i < count; i++) begin
			stim      <= make_instr(kind, i);
			id_valid  <= 1'b1;
			lsu_ready <= random_ready(pct);
			do begin
				@(posedge clock);
			end while (!(id_valid && exu_ready_o));
			// payload stays put until load/store has taken the result
			id_valid  <= 1'b0;
			lsu_ready <= random_ready(pct);
			@(posedge clock);
			while (!(exu_valid_o && lsu_ready)) begin
				lsu_ready <= random_ready(pct);
				@(posedge clock);
			end
			sent++;
		end
		wait (i_checker.checked_count >= sent);
		$display("test %s done: %0d instructions, %0d failures", name, count,
			i_checker.fail_count - fails_before);
	endtask

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#((20 * NUM_INSTR + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout: the DUT did not finish all instructions in time");
		$display("Verification failed");
		$finish;
	end

	initial begin
		int total_fail;
		seed      = 1531;
		sent      = 0;
		tb_fails  = 0;
		reset     = 1'b1;
		id_valid  = 1'b0;
		lsu_ready = 1'b0;
		stim      = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		if (exu_valid_o !== 1'b0 || exu_ready_o !== 1'b1) begin
			$display("[FAIL] reset_state: expected valid=0 ready=1, actual valid=%b ready=%b",
				exu_valid_o, exu_ready_o);
			tb_fails++;
		end
		$display("test reset_state done: %0d failures", tb_fails);
		run_test("alu_ops", 0, N_ALU, 75);
		run_test("operand_sources", 1, N_SRC, 75);
		run_test("csr_data", 2, N_CSR, 75);
		run_test("mem_forwarding", 3, N_MEM, 75);
		// rare downstream ready gives long stalls
		run_test("handshake", 4, N_HS, 25);
		total_fail = i_checker.fail_count + tb_fails;
		if (i_checker.checked_count != NUM_INSTR) begin
			$display("result count mismatch: %0d results for %0d instructions",
				i_checker.checked_count, NUM_INSTR);
			total_fail++;
		end
		$display("checks passed: %0d, checks failed: %0d", i_checker.pass_count, total_fail);
		if (total_fail == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
exe_ctrl_pkg.sv
exe_bus_pkg.sv
exe_if.sv
exe_alu.sv
exe_operand_sel.sv
exe_stage.sv
exe_top.sv
tb_exe_checker.sv
tb_exe.sv

//--- Bender.yml
package:
  name: rv32_exe

export_include_dirs:
  - .

sources:
  - exe_ctrl_pkg.sv
  - exe_bus_pkg.sv
  - exe_if.sv
  - exe_alu.sv
  - exe_operand_sel.sv
  - exe_stage.sv
  - exe_top.sv
  - target: test
    files:
      - tb_exe_checker.sv
      - tb_exe.sv
